/* project.f */
+incdir+common
common/hyper_pkg.sv
source/hyper_cmd_port.sv
source/hyper_rx_fifo.sv
hyper_splitter/hyper_splitter.sv
source/hyper_read_top.sv
sim/hyper_read_asserts.sv
sim/hyper_read_tb.sv

/* Makefile */
# Verilator build and run for the HyperBus read path testbench

VERILATOR ?= verilator
TOP       ?= hyper_read_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/hyper_read_tb.sv */
`timescale 1ns/1ps

/* HyperBus read path testbench
   PHY model, AXI sink with back-pressure and a beat-level reference model */

module hyper_read_tb;

  import hyper_pkg::*;

  localparam int CycleNs = 4;
  localparam int NumCmds = 64;
  localparam int CmdCycles = 200; // Cycle budget per command

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       cmd_req_i;
  byte_off_t  cmd_addr_i;
  beat_len_t  cmd_len_i;
  axi_size_t  cmd_size_i;
  logic       cmd_ack_o;
  logic       phy_valid_i;
  phy_word_t  phy_data_i;
  logic       phy_last_i;
  logic       phy_error_i;
  logic       phy_ready_o;
  logic       r_valid_o;
  axi_data_t  r_data_o;
  logic       r_last_o;
  logic       r_error_o;
  logic       r_ready_i;

  // Words still to send, beats still to receive
  phy_word_t  phy_data_q[$];
  logic       phy_last_q[$];
  logic       phy_err_q[$];
  axi_data_t  exp_data_q[$];
  axi_data_t  exp_mask_q[$];
  logic       exp_last_q[$];
  logic       exp_err_q[$];
  string      exp_name_q[$];

  int   data_errors = 0;
  int   proto_errors = 0;
  int   total_errors;
  int   err_rate = 0;        // One in err_rate words flagged, 0 for none
  logic heavy_stall = 1'b0;

  always #(CycleNs / 2) clk_i = ~clk_i;

  hyper_read_top hyper_read_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_req_i   (cmd_req_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_len_i   (cmd_len_i),
    .cmd_size_i  (cmd_size_i),
    .cmd_ack_o   (cmd_ack_o),
    .phy_valid_i (phy_valid_i),
    .phy_data_i  (phy_data_i),
    .phy_last_i  (phy_last_i),
    .phy_error_i (phy_error_i),
    .phy_ready_o (phy_ready_o),
    .r_valid_o   (r_valid_o),
    .r_data_o    (r_data_o),
    .r_last_o    (r_last_o),
    .r_error_o   (r_error_o),
    .r_ready_i   (r_ready_i)
  );

  task automatic model_command(input int addr, input int len, input int size,
                               input string name);
    int        bytes, base, stop, w0, nwords, prev, last_w, tag, beat_a, beat_end;
    logic      err_w[64];
    logic      err;
    phy_word_t word;
    axi_data_t data, mask;
    bytes  = 1 << size;
    base   = addr / bytes * bytes;
    stop   = base + (len + 1) * bytes;
    w0     = addr / 4 * 4;
    nwords = (stop - w0 + 3) / 4;
    tag    = int'($urandom_range(255));
    for (int j = 0; j < nwords; j++) begin
      for (int b = 0; b < 4; b++) begin
        word[8*b +: 8] = 8'(7 * (w0 + 4 * j + b) + tag);
      end
      err_w[j] = (err_rate != 0) && ($urandom_range(err_rate - 1) == 0);
      phy_data_q.push_back(word);
      phy_last_q.push_back(j == nwords - 1);
      phy_err_q.push_back(err_w[j]);
    end
    prev = -1;
    for (int k = 0; k <= len; k++) begin
      beat_a   = (k == 0) ? addr : base + k * bytes;
      beat_end = base + (k + 1) * bytes;
      last_w   = (beat_end - w0 + 3) / 4 - 1; // Final word this beat waits for
      err      = 1'b0;
      for (int j = prev + 1; j <= last_w; j++) begin
        err |= err_w[j];
      end
      prev = last_w;
      data = '0;
      mask = '0;
      for (int a = beat_a; a < beat_end; a++) begin
        data[8*(a%8) +: 8] = 8'(7 * a + tag);
        mask[8*(a%8) +: 8] = 8'hff;
      end
      exp_data_q.push_back(data);
      exp_mask_q.push_back(mask);
      exp_last_q.push_back(k == len);
      exp_err_q.push_back(err);
      exp_name_q.push_back(name);
    end
  endtask

  task automatic run_command(input int addr, input int len, input int size, input string name);
    model_command(addr, len, size, name);
    @(negedge clk_i);
    cmd_addr_i = byte_off_t'(addr);
    cmd_len_i  = beat_len_t'(len);
    cmd_size_i = axi_size_t'(size);
    cmd_req_i  = 1'b1;
    @(negedge clk_i);
    while (!cmd_ack_o) @(negedge clk_i);
    // Earlier bursts fully drained before this ack
    assert (exp_data_q.size() == len + 1) else begin
      proto_errors++;
      $display("error %s: beats pending at ack, expected %0d, actual %0d",
               name, len + 1, exp_data_q.size());
    end
    cmd_req_i = 1'b0;
    @(negedge clk_i);
    while (cmd_ack_o) @(negedge clk_i);
  endtask

  task automatic check_beat();
    axi_data_t data, mask;
    logic      last, err;
    string     name;
    assert (exp_data_q.size() != 0) else begin
      proto_errors++;
      $display("An AXI beat arrived when no beat was expected");
    end
    if (exp_data_q.size() != 0) begin
      data = exp_data_q.pop_front();
      mask = exp_mask_q.pop_front();
      last = exp_last_q.pop_front();
      err  = exp_err_q.pop_front();
      name = exp_name_q.pop_front();
      assert ((r_data_o & mask) == data) else begin
        data_errors++;
        $display("error %s: data expected %h, actual %h", name, data, r_data_o & mask);
      end
      assert (r_last_o == last) else begin
        data_errors++;
        $display("error %s: last expected %b, actual %b", name, last, r_last_o);
      end
      assert (r_error_o == err) else begin
        data_errors++;
        $display("error %s: error flag expected %b, actual %b", name, err, r_error_o);
      end
    end
  endtask

  initial begin : phy_model
    logic taken;
    taken       = 1'b0;
    phy_valid_i = 1'b0;
    phy_data_i  = '0;
    phy_last_i  = 1'b0;
    phy_error_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (phy_valid_i && taken) phy_valid_i = 1'b0;
      if (!phy_valid_i && phy_data_q.size() != 0 && $urandom_range(3) != 0) begin
        phy_valid_i = 1'b1;
        phy_data_i  = phy_data_q.pop_front();
        phy_last_i  = phy_last_q.pop_front();
        phy_error_i = phy_err_q.pop_front();
      end
      taken = phy_ready_o; // Ready at the coming edge
    end
  end

  initial begin : axi_sink
    int stall;
    stall     = 0;
    r_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (stall > 0) begin
        stall--;
        r_ready_i = 1'b0;
      end else if (heavy_stall && $urandom_range(5) == 0) begin
        stall     = int'($urandom_range(24, 4));
        r_ready_i = 1'b0;
      end else begin
        r_ready_i = $urandom_range(3) != 0;
      end
      if (rst_ni && r_valid_o && r_ready_i) check_beat();
    end
  end

  initial begin : watchdog
    #(CycleNs * (CmdCycles * NumCmds + 10));
    $display("Timeout: the run did not finish within %0d cycles", CmdCycles * NumCmds + 10);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    void'($urandom(32'h6520_6e30));
    rst_ni     = 1'b0;
    cmd_req_i  = 1'b0;
    cmd_addr_i = '0;
    cmd_len_i  = '0;
    cmd_size_i = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int len = 0; len < 16; len++) begin
      run_command(0, len, 3, "aligned");
    end
    for (int n = 0; n < 24; n++) begin
      run_command(int'($urandom_range(7)), int'($urandom_range(15)),
                  int'($urandom_range(2)), "narrow");
    end
    err_rate = 4;
    for (int n = 0; n < 12; n++) begin
      run_command(int'($urandom_range(7)), int'($urandom_range(15)),
                  int'($urandom_range(3)), "error_flag");
    end
    err_rate    = 0;
    heavy_stall = 1'b1;
    for (int n = 0; n < 12; n++) begin
      run_command(int'($urandom_range(7)), int'($urandom_range(15)),
                  int'($urandom_range(3)), "backpressure");
    end
    while (exp_data_q.size() != 0 || phy_data_q.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    total_errors = data_errors + proto_errors
                 + int'(hyper_read_top_inst.read_asserts_inst.fail_cnt);
    $display("Errors: %0d data, %0d protocol, %0d assertion", data_errors, proto_errors,
             hyper_read_top_inst.read_asserts_inst.fail_cnt);
    if (total_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim/hyper_read_asserts.sv */
`timescale 1ns/1ps

/* HyperBus read path protocol checks
   Reset state, four-phase command handshake and AXI/PHY stability */

module hyper_read_asserts (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  cmd_req_i,
  input logic                  cmd_ack_i,
  input logic                  busy_i,
  input logic                  start_i,
  input logic                  phy_ready_i,
  input logic                  rx_valid_i,
  input logic                  rx_ready_i,
  input hyper_pkg::phy_word_t  rx_data_i,
  input logic                  r_valid_i,
  input logic                  r_ready_i,
  input hyper_pkg::axi_data_t  r_data_i,
  input logic                  r_last_i,
  input logic                  r_error_i
);

  int unsigned fail_cnt = 0;

  reset_state: assert property (@(posedge clk_i)
    !rst_ni |-> !cmd_ack_i && !r_valid_i && !r_last_i && phy_ready_i)
    else begin
      $error("Outputs left their reset values during reset");
      fail_cnt++;
    end

  ack_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_ack_i && cmd_req_i |=> cmd_ack_i)
    else begin
      $error("Ack dropped while req was still high");
      fail_cnt++;
    end

  ack_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_ack_i && !cmd_req_i |=> !cmd_ack_i)
    else begin
      $error("Ack stayed high after req fell");
      fail_cnt++;
    end

  ack_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !cmd_ack_i && !cmd_req_i |=> !cmd_ack_i)
    else begin
      $error("Ack rose without a request");
      fail_cnt++;
    end

  // New burst only after the previous one finished
  ack_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_ack_i) |-> start_i && !$past(busy_i))
    else begin
      $error("Command accepted during a burst or without start");
      fail_cnt++;
    end

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_last_i)
      && $stable(r_error_i))
    else begin
      $error("AXI beat changed while waiting for ready");
      fail_cnt++;
    end

  rx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_i && !rx_ready_i |=> rx_valid_i && $stable(rx_data_i))
    else begin
      $error("Receive FIFO word changed before the splitter took it");
      fail_cnt++;
    end

endmodule

bind hyper_read_top hyper_read_asserts read_asserts_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cmd_req_i   (cmd_req_i),
  .cmd_ack_i   (cmd_ack_o),
  .busy_i      (busy),
  .start_i     (start),
  .phy_ready_i (phy_ready_o),
  .rx_valid_i  (rx_valid),
  .rx_ready_i  (rx_ready),
  .rx_data_i   (rx_data),
  .r_valid_i   (r_valid_o),
  .r_ready_i   (r_ready_i),
  .r_data_i    (r_data_o),
  .r_last_i    (r_last_o),
  .r_error_i   (r_error_o)
);

/* source/hyper_read_top.sv */
`timescale 1ns/1ps

/* HyperBus read data path
   Command port, receive FIFO and splitter between the PHY and AXI */

module hyper_read_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_req_i,
  input  hyper_pkg::byte_off_t  cmd_addr_i,
  input  hyper_pkg::beat_len_t  cmd_len_i,
  input  hyper_pkg::axi_size_t  cmd_size_i,
  output logic                  cmd_ack_o,
  input  logic                  phy_valid_i,
  input  hyper_pkg::phy_word_t  phy_data_i,
  input  logic                  phy_last_i,
  input  logic                  phy_error_i,
  output logic                  phy_ready_o,
  output logic                  r_valid_o,
  output hyper_pkg::axi_data_t  r_data_o,
  output logic                  r_last_o,
  output logic                  r_error_o,
  input  logic                  r_ready_i
);

  import hyper_pkg::*;

  logic       start, busy;
  byte_off_t  start_addr;
  beat_len_t  start_len;
  axi_size_t  start_size;

  logic       rx_valid, rx_ready, rx_last, rx_error;
  phy_word_t  rx_data;

  hyper_cmd_port cmd_port_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_req_i    (cmd_req_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_len_i    (cmd_len_i),
    .cmd_size_i   (cmd_size_i),
    .busy_i       (busy),
    .cmd_ack_o    (cmd_ack_o),
    .start_o      (start),
    .start_addr_o (start_addr),
    .start_len_o  (start_len),
    .start_size_o (start_size)
  );

  hyper_rx_fifo rx_fifo_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_valid_i (phy_valid_i),
    .wr_data_i  (phy_data_i),
    .wr_last_i  (phy_last_i),
    .wr_error_i (phy_error_i),
    .wr_ready_o (phy_ready_o),
    .rd_ready_i (rx_ready),
    .rd_valid_o (rx_valid),
    .rd_data_o  (rx_data),
    .rd_last_o  (rx_last),
    .rd_error_o (rx_error)
  );

  hyper_splitter splitter_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .start_addr_i (start_addr),
    .len_i        (start_len),
    .size_i       (start_size),
    .busy_o       (busy),
    .phy_valid_i  (rx_valid),
    .phy_data_i   (rx_data),
    .phy_last_i   (rx_last),
    .phy_error_i  (rx_error),
    .phy_ready_o  (rx_ready),
    .axi_valid_o  (r_valid_o),
    .axi_ready_i  (r_ready_i),
    .axi_data_o   (r_data_o),
    .axi_last_o   (r_last_o),
    .axi_error_o  (r_error_o)
  );

endmodule

/* hyper_splitter/hyper_splitter.sv */
`timescale 1ns/1ps
`include "hyper_macros.svh"

/* HyperBus read splitter
   Packs PHY words into AXI words and emits one sized, possibly
   unaligned AXI read beat per command beat with last and error */

module hyper_splitter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  hyper_pkg::byte_off_t  start_addr_i,
  input  hyper_pkg::beat_len_t  len_i,
  input  hyper_pkg::axi_size_t  size_i,
  output logic                  busy_o,
  input  logic                  phy_valid_i,
  input  hyper_pkg::phy_word_t  phy_data_i,
  input  logic                  phy_last_i,
  input  logic                  phy_error_i,
  output logic                  phy_ready_o,
  output logic                  axi_valid_o,
  input  logic                  axi_ready_i,
  output hyper_pkg::axi_data_t  axi_data_o,
  output logic                  axi_last_o,
  output logic                  axi_error_o
);

  import hyper_pkg::*;

  localparam int unsigned PhyDW     = $bits(phy_word_t);
  localparam int unsigned WordBytes = 2 * `HYPER_NUM_PHYS;
  localparam int unsigned LaneW     = $clog2(`HYPER_AXI_DW / 8);
  localparam int unsigned WordW     = $clog2(WordBytes);

  splitter_state_e state_d, state_q;
  burst_cnt_t      axi_addr_d, axi_addr_q;
  burst_cnt_t      phy_cnt_d, phy_cnt_q;
  burst_cnt_t      end_d, end_q;
  axi_size_t       size_d, size_q;
  logic            err_d, err_q;
  logic            phy_done_d, phy_done_q;
  axi_data_t       buf_d, buf_q;

  burst_cnt_t              start_bytes, beat_bytes, beat_end, phy_cnt_next;
  logic [LaneW-WordW-1:0]  phy_half;
  logic                    phy_hs, axi_hs, last_beat;

  assign start_bytes  = burst_cnt_t'(1) << size_i;
  assign beat_bytes   = burst_cnt_t'(1) << size_q;
  assign beat_end     = (axi_addr_q & ~(beat_bytes - burst_cnt_t'(1))) + beat_bytes;
  assign phy_cnt_next = phy_cnt_q + burst_cnt_t'(WordBytes);
  assign phy_half     = phy_cnt_q[LaneW-1:WordW]; // Buffer half for the next word
  assign last_beat    = beat_end == end_q;

  assign busy_o      = state_q != Idle;
  assign phy_ready_o = state_q == Sample;
  assign axi_valid_o = state_q == Emit;
  assign axi_data_o  = buf_q;
  assign axi_last_o  = axi_valid_o && last_beat;
  assign axi_error_o = err_q;

  assign phy_hs = phy_valid_i && phy_ready_o;
  assign axi_hs = axi_valid_o && axi_ready_i;

  always_comb begin
    state_d    = state_q;
    axi_addr_d = axi_addr_q;
    phy_cnt_d  = phy_cnt_q;
    end_d      = end_q;
    size_d     = size_q;
    err_d      = err_q;
    phy_done_d = phy_done_q;
    buf_d      = buf_q;
    case (state_q)
      Idle: begin
        if (start_i) begin
          axi_addr_d = burst_cnt_t'(start_addr_i);
          // PHY stream starts on a word boundary
          phy_cnt_d  = burst_cnt_t'(start_addr_i) & ~burst_cnt_t'(WordBytes - 1);
          end_d      = (burst_cnt_t'(start_addr_i) & ~(start_bytes - burst_cnt_t'(1)))
                     + ((burst_cnt_t'(len_i) + burst_cnt_t'(1)) << size_i);
          size_d     = size_i;
          err_d      = 1'b0;
          phy_done_d = 1'b0;
          state_d    = WaitData;
        end
      end
      WaitData: begin
        if (phy_valid_i) begin
          state_d = Sample;
        end
      end
      Sample: begin
        if (phy_hs) begin
          buf_d[phy_half*PhyDW +: PhyDW] = phy_data_i;
          phy_cnt_d  = phy_cnt_next;
          err_d      = err_q | phy_error_i;
          phy_done_d = phy_last_i;
          if (phy_cnt_next >= beat_end || phy_last_i) begin
            state_d = Emit; // Beat covered or PHY burst over
          end
        end
      end
      Emit: begin
        if (axi_hs) begin
          axi_addr_d = beat_end;
          err_d      = 1'b0;
          if (last_beat) begin
            state_d = Idle;
          end else if (phy_cnt_q >= beat_end + beat_bytes) begin
            state_d = Emit; // Next narrow beat already buffered
          end else if (phy_done_q) begin
            state_d = Idle; // Short PHY burst, nothing more to come
          end else begin
            state_d = WaitData;
          end
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      axi_addr_q <= '0;
      phy_cnt_q  <= '0;
      end_q      <= '0;
      size_q     <= '0;
      err_q      <= 1'b0;
      phy_done_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      axi_addr_q <= axi_addr_d;
      phy_cnt_q  <= phy_cnt_d;
      end_q      <= end_d;
      size_q     <= size_d;
      err_q      <= err_d;
      phy_done_q <= phy_done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
  end

endmodule

/* source/hyper_rx_fifo.sv */
`timescale 1ns/1ps
`include "hyper_macros.svh"

/* HyperBus receive FIFO
   Single-clock circular buffer for PHY words with their last and error bits */

module hyper_rx_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wr_valid_i,
  input  hyper_pkg::phy_word_t  wr_data_i,
  input  logic                  wr_last_i,
  input  logic                  wr_error_i,
  output logic                  wr_ready_o,
  input  logic                  rd_ready_i,
  output logic                  rd_valid_o,
  output hyper_pkg::phy_word_t  rd_data_o,
  output logic                  rd_last_o,
  output logic                  rd_error_o
);

  import hyper_pkg::*;

  localparam int unsigned Depth = `HYPER_FIFO_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  phy_word_t         data_mem [Depth];
  logic [Depth-1:0]  last_mem;
  logic [Depth-1:0]  error_mem;
  logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]   count_q;
  logic              push, pop;

  assign wr_ready_o = count_q != CntW'(Depth);
  assign rd_valid_o = count_q != '0;
  assign push       = wr_valid_i && wr_ready_o;
  assign pop        = rd_valid_o && rd_ready_i;

  assign rd_data_o  = data_mem[rd_ptr_q];
  assign rd_last_o  = last_mem[rd_ptr_q];
  assign rd_error_o = error_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push) - CntW'(pop); // Both at once keeps level
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q]  <= wr_data_i;
      last_mem[wr_ptr_q]  <= wr_last_i;
      error_mem[wr_ptr_q] <= wr_error_i;
    end
  end

endmodule

/* source/hyper_cmd_port.sv */
`timescale 1ns/1ps

/* HyperBus read command port
   Four-phase req/ack responder that latches a read command
   and fires a one-cycle start pulse to the splitter */

module hyper_cmd_port (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_req_i,
  input  hyper_pkg::byte_off_t  cmd_addr_i,
  input  hyper_pkg::beat_len_t  cmd_len_i,
  input  hyper_pkg::axi_size_t  cmd_size_i,
  input  logic                  busy_i,
  output logic                  cmd_ack_o,
  output logic                  start_o,
  output hyper_pkg::byte_off_t  start_addr_o,
  output hyper_pkg::beat_len_t  start_len_o,
  output hyper_pkg::axi_size_t  start_size_o
);

  logic ack_q; // Low = waiting for req, high = acked
  logic start_q;
  logic accept;

  // No new burst while the splitter still runs one
  assign accept = !ack_q && cmd_req_i && !busy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      if (accept) begin
        ack_q <= 1'b1;
      end else if (ack_q && !cmd_req_i) begin
        ack_q <= 1'b0; // Return to zero phase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      start_addr_o <= cmd_addr_i;
      start_len_o  <= cmd_len_i;
      start_size_o <= cmd_size_i;
    end
  end

  assign cmd_ack_o = ack_q;
  assign start_o   = start_q;

endmodule

/* common/hyper_pkg.sv */
/* HyperBus read path types
   Width typedefs and the splitter FSM encoding */

`include "hyper_macros.svh"

package hyper_pkg;

  // One AXI read data word
  typedef logic [`HYPER_AXI_DW-1:0] axi_data_t;

  // One word from the PHYs, 16 bits per PHY
  typedef logic [16*`HYPER_NUM_PHYS-1:0] phy_word_t;

  // Byte lane inside an AXI word
  typedef logic [$clog2(`HYPER_AXI_DW/8)-1:0] byte_off_t;

  // Byte position inside a burst
  typedef logic [`HYPER_BURST_W-1:0] burst_cnt_t;

  // AXI beats minus one
  typedef logic [3:0] beat_len_t;

  // log2 of bytes per beat, 0 to 3 are legal
  typedef logic [2:0] axi_size_t;

  typedef enum logic [1:0] {
    Idle,
    WaitData,
    Sample,
    Emit
  } splitter_state_e;

endpackage

/* common/hyper_macros.svh */
/* HyperBus read path dimensions
   Fixed widths and depths shared by the package and the RTL */

`ifndef HYPER_MACROS_SVH
`define HYPER_MACROS_SVH

// AXI read data width in bits
`define HYPER_AXI_DW 64

// 16-bit PHYs working side by side
`define HYPER_NUM_PHYS 2

// Byte counters inside one burst
`define HYPER_BURST_W 8

// Receive FIFO entries
`define HYPER_FIFO_DEPTH 4

`endif
